// File: logic/cachePkg.sv
package cachePkg;

    // Address split is fixed: tag 31:4, set 3:2, byte offset 1:0
    localparam int tagWidth = 28;
    localparam int setCount = 4;

    typedef logic [31:0]         wordType;
    typedef logic [tagWidth-1:0] tagType;
    typedef logic [1:0]          setIndexType;
    typedef logic [2:0]          funct3Type;

    // MMIO word, never allocated in the cache
    localparam wordType uncachedAddr = 32'h000000FC;

    // RISC-V load/store funct3 encodings
    localparam funct3Type funct3Byte  = 3'b000;  // lb / sb
    localparam funct3Type funct3Half  = 3'b001;  // lh / sh
    localparam funct3Type funct3Word  = 3'b010;  // lw / sw
    localparam funct3Type funct3ByteU = 3'b100;  // lbu
    localparam funct3Type funct3HalfU = 3'b101;  // lhu

    // Controller states
    // idle also covers the lookup cycle right after a request
    typedef enum logic [1:0] {
        idle,
        writeBack,   // Dirty victim sent, fetch request next
        fetch,       // Waiting for memReadValid
        respond      // respValid cycle
    } cacheStateType;

endpackage

// File: logic/storeMerger.sv
module storeMerger import cachePkg::*; (
    input  wordType    baseWord,
    input  wordType    storeData,
    input  logic [1:0] offset,
    input  funct3Type  funct3,
    output wordType    mergedWord
);

    always_comb begin
        mergedWord = baseWord;
        case (funct3)
            funct3Byte: begin
                mergedWord[8*offset +: 8] = storeData[7:0];
            end
            funct3Half: begin
                // Aligned halfword, offset bit 0 is ignored
                if (offset[1]) begin
                    mergedWord[31:16] = storeData[15:0];
                end else begin
                    mergedWord[15:0] = storeData[15:0];
                end
            end
            funct3Word: begin
                mergedWord = storeData;
            end
            default: begin
                mergedWord = baseWord;  // Not a store code
            end
        endcase
    end

endmodule

// File: logic/loadFormatter.sv
module loadFormatter import cachePkg::*; (
    input  wordType    word,
    input  logic [1:0] offset,
    input  funct3Type  funct3,
    output wordType    loadData
);

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    assign byteSel = word[8*offset +: 8];
    assign halfSel = offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (funct3)
            funct3Byte: begin
                loadData = {{24{byteSel[7]}}, byteSel};
            end
            funct3ByteU: begin
                loadData = {24'b0, byteSel};
            end
            funct3Half: begin
                loadData = {{16{halfSel[15]}}, halfSel};
            end
            funct3HalfU: begin
                loadData = {16'b0, halfSel};
            end
            funct3Word: begin
                loadData = word;
            end
            default: begin
                loadData = '0;
            end
        endcase
    end

endmodule

// File: logic/cacheSetArray.sv
module cacheSetArray import cachePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  wordType addr,
    input  logic    fillEn,
    input  logic    fillDirty,
    input  logic    writeEn,
    input  logic    touchEn,
    input  wordType wdata,
    output logic    hit,
    output logic    hitWay,
    output wordType hitData,
    output logic    victimDirty,
    output tagType  victimTag,
    output wordType victimData
);

    logic [1:0] valid [setCount];
    logic [1:0] dirty [setCount];
    logic       lru [setCount];     // Names the way to evict next
    tagType     tags [setCount][2];
    wordType    data [setCount][2];

    setIndexType set;
    tagType      tag;
    logic [1:0]  wayHit;
    logic        victim;

    assign set = addr[3:2];
    assign tag = addr[31:4];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = valid[set][w] && (tags[set][w] == tag);
        end
    end

    assign hit     = |wayHit;
    assign hitWay  = wayHit[1];
    assign hitData = data[set][hitWay];

    assign victim      = lru[set];
    assign victimDirty = valid[set][victim] && dirty[set][victim];
    assign victimTag   = tags[set][victim];
    assign victimData  = data[set][victim];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < setCount; s++) begin
                valid[s] <= 2'b00;
                dirty[s] <= 2'b00;
                lru[s]   <= 1'b0;
            end
        end else if (fillEn) begin
            valid[set][victim] <= 1'b1;
            dirty[set][victim] <= fillDirty;
            lru[set]           <= ~victim;
        end else if (writeEn) begin
            dirty[set][hitWay] <= 1'b1;
            lru[set]           <= ~hitWay;
        end else if (touchEn) begin
            lru[set] <= ~hitWay;  // Other way becomes the victim
        end
    end

    // Tag and data storage
    always_ff @(posedge clk) begin
        if (fillEn) begin
            tags[set][victim] <= tag;
            data[set][victim] <= wdata;
        end else if (writeEn) begin
            data[set][hitWay] <= wdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(wayHit[0] && wayHit[1]));

endmodule

// File: logic/cacheController.sv
module cacheController import cachePkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      reqValid,
    input  logic      reqWrite,
    input  wordType   reqAddr,
    input  funct3Type reqFunct3,
    input  wordType   reqWdata,
    input  logic      memReadValid,
    input  wordType   memRdata,
    input  logic      hit,
    input  logic      hitWay,
    input  logic      victimDirty,
    input  tagType    victimTag,
    input  wordType   victimData,
    input  wordType   mergedWord,
    input  wordType   formattedLoad,
    output logic      busy,
    output logic      respValid,
    output wordType   respRdata,
    output logic      memRead,
    output logic      memWrite,
    output wordType   memAddr,
    output wordType   memWdata,
    output wordType   curAddr,
    output funct3Type curFunct3,
    output wordType   curWdata,
    output logic      baseSel,
    output logic      fillEn,
    output logic      writeEn,
    output logic      touchEn,
    output logic      fillDirty
);

    cacheStateType state;
    logic    lookup;      // Tag compare cycle on the latched address
    logic    curWrite;
    wordType storeData;
    logic    uncached;
    logic    missDirty;

    assign uncached  = ({curAddr[31:2], 2'b00} == uncachedAddr);
    assign missDirty = lookup && !uncached && !hit && victimDirty;

    assign busy      = lookup || (state != idle);
    assign respValid = (state == respond);

    // Memory strobes
    assign memWrite = missDirty || (lookup && uncached && curWrite);
    assign memRead  = (state == writeBack)
                   || (lookup && uncached && !curWrite)
                   || (lookup && !uncached && !hit && !victimDirty);
    assign memAddr  = missDirty ? {victimTag, curAddr[3:2], 2'b00} : {curAddr[31:2], 2'b00};
    assign memWdata = uncached ? storeData : victimData;  // MMIO stores go out as a full word

    // On a load fill the merger gets the loaded bytes back, so the fetched word is kept
    assign curWdata  = curWrite ? storeData : formattedLoad;
    assign baseSel   = (state == fetch);
    assign fillEn    = (state == fetch) && memReadValid && !uncached;
    assign fillDirty = curWrite;
    assign touchEn   = lookup && !uncached && hit;
    assign writeEn   = touchEn && curWrite;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= idle;
            lookup <= 1'b0;
        end else begin
            lookup <= 1'b0;
            case (state)
                idle: begin
                    if (lookup) begin
                        if (uncached) begin
                            state <= curWrite ? respond : fetch;
                        end else if (hit) begin
                            state <= respond;
                        end else if (victimDirty) begin
                            state <= writeBack;
                        end else begin
                            state <= fetch;
                        end
                    end else if (reqValid) begin
                        lookup <= 1'b1;
                    end
                end
                writeBack: state <= fetch;
                fetch: begin
                    if (memReadValid) begin
                        state <= respond;
                    end
                end
                respond: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // Request registers
    always_ff @(posedge clk) begin
        if (reqValid && !busy) begin
            curAddr   <= reqAddr;
            curWrite  <= reqWrite;
            curFunct3 <= reqFunct3;
            storeData <= reqWdata;
        end
    end

    // Load result, from hitData on a hit or memRdata on a fetch
    always_ff @(posedge clk) begin
        if (!curWrite && (touchEn || (baseSel && memReadValid))) begin
            respRdata <= formattedLoad;
        end
    end

    assert property (@(posedge clk) disable iff (rst) busy |-> !reqValid);
    assert property (@(posedge clk) disable iff (rst) memReadValid |-> state == fetch);
    // Loads must fill the fetched word untouched
    assert property (@(posedge clk) disable iff (rst)
        (fillEn && !curWrite) |-> mergedWord == memRdata);

endmodule

// File: logic/dataCacheTop.sv
module dataCacheTop import cachePkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      reqValid,
    input  logic      reqWrite,
    input  wordType   reqAddr,
    input  funct3Type reqFunct3,
    input  wordType   reqWdata,
    input  logic      memReadValid,
    input  wordType   memRdata,
    output logic      busy,
    output logic      respValid,
    output wordType   respRdata,
    output logic      memRead,
    output logic      memWrite,
    output wordType   memAddr,
    output wordType   memWdata
);

    wordType   curAddr;
    funct3Type curFunct3;
    wordType   curWdata;
    logic      baseSel;
    logic      fillEn;
    logic      writeEn;
    logic      touchEn;
    logic      fillDirty;
    logic      hit;
    logic      hitWay;
    wordType   hitData;
    logic      victimDirty;
    tagType    victimTag;
    wordType   victimData;
    wordType   baseWord;
    wordType   mergedWord;
    wordType   formattedLoad;

    assign baseWord = baseSel ? memRdata : hitData;  // Fill path takes the memory word

    cacheController u_controller (
        .clk, .rst, .reqValid, .reqWrite, .reqAddr, .reqFunct3, .reqWdata,
        .memReadValid, .memRdata, .hit, .hitWay, .victimDirty, .victimTag, .victimData,
        .mergedWord, .formattedLoad, .busy, .respValid, .respRdata,
        .memRead, .memWrite, .memAddr, .memWdata, .curAddr, .curFunct3, .curWdata,
        .baseSel, .fillEn, .writeEn, .touchEn, .fillDirty
    );

    cacheSetArray u_setArray (
        .clk, .rst, .addr(curAddr), .fillEn, .fillDirty, .writeEn, .touchEn,
        .wdata(mergedWord), .hit, .hitWay, .hitData, .victimDirty, .victimTag, .victimData
    );

    storeMerger u_storeMerger (
        .baseWord, .storeData(curWdata), .offset(curAddr[1:0]), .funct3(curFunct3),
        .mergedWord
    );

    loadFormatter u_loadFormatter (
        .word(baseWord), .offset(curAddr[1:0]), .funct3(curFunct3), .loadData(formattedLoad)
    );

endmodule

// File: test/memoryModel.sv
module memoryModel import cachePkg::*; (
    input  logic    clk,
    input  logic    memRead,
    input  logic    memWrite,
    input  wordType memAddr,
    input  wordType memWdata,
    output logic    memReadValid,
    output wordType memRdata
);

    wordType     store [wordType];   // Sparse, only written words are kept
    logic [31:0] rngState = 32'hf148;
    int unsigned waitLeft = 0;
    wordType     readAddr = '0;
    logic        readValid = 1'b0;
    wordType     readData = '0;

    assign memReadValid = readValid;
    assign memRdata     = readData;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Content of a word never written
    function automatic wordType fillPattern(input wordType a);
        return a ^ {a[15:0], a[31:16]} ^ 32'hA5C3_0F96;
    endfunction

    always @(negedge clk) begin
        readValid <= 1'b0;
        if (memWrite) begin
            store[memAddr] = memWdata;
        end
        if (memRead) begin
            rngState = xorshift(rngState);
            waitLeft = rngState % 4 + 1;  // 1 to 4 cycles
            readAddr = memAddr;
        end else if (waitLeft > 0) begin
            waitLeft = waitLeft - 1;
            if (waitLeft == 0) begin
                readValid <= 1'b1;
                readData  <= store.exists(readAddr) ? store[readAddr] : fillPattern(readAddr);
            end
        end
    end

endmodule

// File: test/cacheTb.sv
module cacheTb import cachePkg::*; ();

    localparam int period       = 40;
    localparam int requestCount = 60;  // Upper bound on requests issued below
    localparam int worstCycles  = 10;  // Dirty miss with the slowest memory reply

    logic      clk, rst, reqValid, reqWrite, memReadValid;
    logic      busy, respValid, memRead, memWrite;
    wordType   reqAddr, reqWdata, memRdata, respRdata, memAddr, memWdata;
    funct3Type reqFunct3;

    // Reference model
    wordType    archMem [wordType];
    logic [1:0] mValid [setCount] = '{default: '0};
    logic [1:0] mDirty [setCount] = '{default: '0};
    logic       mLru [setCount] = '{default: '0};
    tagType     mTag [setCount][2];

    // Expectations for the request in flight
    int      expReads, expWrites, expRdCycle;
    logic    expLoad = 1'b0;
    logic    expFixed = 1'b0;
    wordType expRdAddr, expWrAddr, expWrData, expRdata;
    int      reqCycle, readCount, writeCount;
    logic    pending = 1'b0;  // Request accepted, response not seen yet
    int      errorCount = 0;
    int      testCount = 0;

    dataCacheTop u_dut (.*);
    memoryModel u_memory (.*);

    always #(period / 2) clk = ~clk;

    // Cycle 1 is the first cycle after reqValid
    always @(posedge clk) begin
        if (reqValid) begin
            reqCycle   <= 1;
            readCount  <= 0;
            writeCount <= 0;
            pending    <= 1'b1;
        end else begin
            reqCycle   <= reqCycle + 1;
            readCount  <= readCount + (memRead ? 1 : 0);
            writeCount <= writeCount + (memWrite ? 1 : 0);
            if (respValid) begin
                pending <= 1'b0;
            end
        end
    end

    function automatic wordType fillPattern(input wordType a);
        return a ^ {a[15:0], a[31:16]} ^ 32'hA5C3_0F96;
    endfunction

    function automatic wordType readArch(input wordType a);
        return archMem.exists(a) ? archMem[a] : fillPattern(a);
    endfunction

    function automatic wordType formatLoad(input wordType w, input logic [1:0] off,
                                           input funct3Type f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * off));
        h = 16'(w >> (16 * off[1]));
        case (f3)
            funct3Byte:  return {{24{b[7]}}, b};
            funct3ByteU: return {24'b0, b};
            funct3Half:  return {{16{h[15]}}, h};
            funct3HalfU: return {16'b0, h};
            funct3Word:  return w;
            default:     return '0;
        endcase
    endfunction

    function automatic wordType mergeStore(input wordType old, input wordType d,
                                           input logic [1:0] off, input funct3Type f3);
        wordType mask;
        int      sh;
        mask = (f3 == funct3Byte) ? 32'hFF : (f3 == funct3Half) ? 32'hFFFF : 32'hFFFF_FFFF;
        sh   = (f3 == funct3Byte) ? 8 * off : (f3 == funct3Half) ? 16 * off[1] : 0;
        return (old & ~(mask << sh)) | ((d << sh) & (mask << sh));
    endfunction

    task automatic reportValue(input string name, input wordType got, input wordType want);
        $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want);
        errorCount++;
    endtask

    task automatic reportEvent(input string what);
        $display("%0t: %s", $time, what);
        errorCount++;
    endtask

    task automatic issueRequest(input logic write, input wordType addr, input funct3Type f3,
                                input wordType wdata);
        wordType     lineAddr;
        setIndexType s;
        logic        hitNow;
        logic        w;
        int          waited;
        @(negedge clk);  // Previous response is checked by now
        lineAddr   = {addr[31:2], 2'b00};
        s          = addr[3:2];
        hitNow     = 1'b0;
        w          = mLru[s];
        expReads   = 0;
        expWrites  = 0;
        expRdCycle = 1;
        expRdAddr  = lineAddr;
        expFixed   = 1'b0;
        if (lineAddr == uncachedAddr) begin
            expReads  = write ? 0 : 1;
            expWrites = write ? 1 : 0;
            expWrAddr = lineAddr;
            expWrData = wdata;  // Full word whatever the size code
            expFixed  = write;
            if (write) begin
                archMem[lineAddr] = wdata;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (mValid[s][i] && mTag[s][i] == addr[31:4]) begin
                    hitNow = 1'b1;
                    w      = i[0];
                end
            end
            if (hitNow) begin
                expFixed = 1'b1;
            end else begin
                if (mValid[s][w] && mDirty[s][w]) begin
                    expWrites  = 1;
                    expWrAddr  = {mTag[s][w], s, 2'b00};
                    expWrData  = readArch(expWrAddr);
                    expRdCycle = 2;  // Writeback goes first
                end
                expReads     = 1;
                mValid[s][w] = 1'b1;
                mDirty[s][w] = 1'b0;
                mTag[s][w]   = addr[31:4];
            end
            mDirty[s][w] = mDirty[s][w] | write;
            mLru[s]      = ~w;
            if (write) begin
                archMem[lineAddr] = mergeStore(readArch(lineAddr), wdata, addr[1:0], f3);
            end
        end
        expLoad   = !write;
        expRdata  = formatLoad(readArch(lineAddr), addr[1:0], f3);
        reqValid  = 1'b1;
        reqWrite  = write;
        reqAddr   = addr;
        reqFunct3 = f3;
        reqWdata  = wdata;
        @(negedge clk);
        reqValid = 1'b0;
        waited   = 0;
        while (!respValid && waited < 2 * worstCycles) begin
            @(negedge clk);
            waited++;
        end
        if (!respValid) begin
            reportEvent($sformatf("no response to the request for address %h", addr));
        end
    endtask

    task automatic loadAllFormats(input wordType base);
        for (int off = 0; off < 4; off++) begin
            issueRequest(1'b0, base + off, funct3Byte, '0);
            issueRequest(1'b0, base + off, funct3ByteU, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            issueRequest(1'b0, base + off, funct3Half, '0);
            issueRequest(1'b0, base + off, funct3HalfU, '0);
        end
        issueRequest(1'b0, base, funct3Word, '0);
    endtask

    task automatic finishTest(input string name, input int mark);
        @(negedge clk);
        testCount++;
        if (errorCount == mark) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: %0d errors", name, errorCount - mark);
        end
    endtask

    assert property (@(posedge clk) disable iff (rst)
        respValid && expLoad |-> respRdata == expRdata)
        else reportValue("respRdata", $sampled(respRdata), expRdata);
    assert property (@(posedge clk) disable iff (rst) memWrite |-> expWrites == 1 && reqCycle == 1)
        else reportEvent("memWrite strobe where none was expected");
    assert property (@(posedge clk) disable iff (rst) memWrite |-> memAddr == expWrAddr)
        else reportValue("memAddr (write)", $sampled(memAddr), expWrAddr);
    assert property (@(posedge clk) disable iff (rst) memWrite |-> memWdata == expWrData)
        else reportValue("memWdata", $sampled(memWdata), expWrData);
    assert property (@(posedge clk) disable iff (rst)
        memRead |-> expReads == 1 && reqCycle == expRdCycle)
        else reportEvent("memRead strobe where none was expected");
    assert property (@(posedge clk) disable iff (rst) memRead |-> memAddr == expRdAddr)
        else reportValue("memAddr (read)", $sampled(memAddr), expRdAddr);
    assert property (@(posedge clk) disable iff (rst)
        respValid |-> readCount == expReads && writeCount == expWrites)
        else reportEvent("memory strobe count wrong at the response");
    assert property (@(posedge clk) disable iff (rst) respValid && expFixed |-> reqCycle == 2)
        else reportValue("respValid cycle", $sampled(reqCycle), 2);
    // High from the cycle after the request through the response cycle
    assert property (@(posedge clk) disable iff (rst) busy == pending)
        else reportValue("busy", $sampled(busy), $sampled(pending));

    initial begin
        int mark;
        clk       = 1'b0;
        rst       = 1'b1;
        reqValid  = 1'b0;
        reqWrite  = 1'b0;
        reqAddr   = '0;
        reqFunct3 = '0;
        reqWdata  = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        mark = errorCount;
        assert (!respValid && !busy && !memRead && !memWrite)
            else reportEvent("cache outputs not idle after reset");
        issueRequest(1'b0, 32'h0000_0100, funct3Word, '0);
        finishTest("reset", mark);

        mark = errorCount;
        issueRequest(1'b0, 32'h0000_0106, funct3HalfU, '0);
        issueRequest(1'b0, 32'h0000_0106, funct3HalfU, '0);
        finishTest("miss then hit", mark);

        // One word with top bits set, one with them clear
        mark = errorCount;
        issueRequest(1'b1, 32'h0000_0200, funct3Word, 32'h80F1_7F22);
        issueRequest(1'b1, 32'h0000_0214, funct3Word, 32'h7F01_A3C4);
        loadAllFormats(32'h0000_0200);
        loadAllFormats(32'h0000_0214);
        finishTest("load formatting", mark);

        mark = errorCount;
        issueRequest(1'b1, 32'h0000_0309, funct3Byte, 32'h0000_00AB);
        issueRequest(1'b1, 32'h0000_040A, funct3Half, 32'h0000_BEEF);
        issueRequest(1'b1, 32'h0000_0308, funct3Half, 32'h0000_1357);
        issueRequest(1'b1, 32'h0000_040B, funct3Byte, 32'h0000_00C6);
        issueRequest(1'b0, 32'h0000_0308, funct3Word, '0);
        issueRequest(1'b0, 32'h0000_0408, funct3Word, '0);
        issueRequest(1'b0, 32'h0000_0508, funct3Word, '0);  // Dirty victim
        issueRequest(1'b0, 32'h0000_0608, funct3Word, '0);
        issueRequest(1'b1, 32'h0000_0708, funct3Word, 32'h2468_ACE0);  // Clean victim
        issueRequest(1'b0, 32'h0000_0308, funct3Word, '0);
        issueRequest(1'b0, 32'h0000_0408, funct3Word, '0);
        finishTest("store merge and eviction", mark);

        mark = errorCount;
        issueRequest(1'b0, 32'h0000_0904, funct3Word, '0);  // A
        issueRequest(1'b0, 32'h0000_0A04, funct3Word, '0);  // B
        issueRequest(1'b0, 32'h0000_0904, funct3Word, '0);
        issueRequest(1'b0, 32'h0000_0B04, funct3Word, '0);  // C replaces B
        issueRequest(1'b0, 32'h0000_0904, funct3Word, '0);
        issueRequest(1'b0, 32'h0000_0A04, funct3Word, '0);
        finishTest("LRU replacement", mark);

        // Set 3 shares its index with the MMIO word
        mark = errorCount;
        issueRequest(1'b0, 32'h0000_010C, funct3Word, '0);
        issueRequest(1'b0, uncachedAddr, funct3Word, '0);
        issueRequest(1'b1, uncachedAddr, funct3Byte, 32'h1234_5678);
        issueRequest(1'b0, uncachedAddr + 1, funct3ByteU, '0);
        issueRequest(1'b0, uncachedAddr, funct3Word, '0);
        issueRequest(1'b0, 32'h0000_020C, funct3Word, '0);  // Victim still way 1
        issueRequest(1'b0, 32'h0000_010C, funct3Word, '0);
        finishTest("uncached MMIO", mark);

        $display("Tests run: %0d, failed checks: %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #((requestCount * worstCycles + 40) * period);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: files.f
logic/cachePkg.sv
logic/storeMerger.sv
logic/loadFormatter.sv
logic/cacheSetArray.sv
logic/cacheController.sv
logic/dataCacheTop.sv
test/memoryModel.sv
test/cacheTb.sv

// File: Makefile
.PHONY: all build lint clean

all: build
	@out=$$(./obj_dir/VcacheTb); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

build:
	verilator --binary --timing --assert -f files.f --top-module cacheTb -Mdir obj_dir

lint:
	verilator --lint-only --timing -f files.f --top-module cacheTb

clean:
	rm -rf obj_dir
